// File: all.f
verilog/xc_pkg.sv
verilog/xc_control.sv
verilog/xc_delay_line.sv
verilog/xc_autocorr.sv
verilog/xc_crosscorr.sv
verilog/xc_result_bank.sv
verilog/xc_top.sv
bench/xc_assertions.sv
bench/xc_tb.sv

// File: bench/xc_assertions.sv
// bound into xc_control; checks hold only outside reset, and a failure is reported through $error.
module xc_assertions import xc_pkg::*; (
	input logic        integration_clk,
	input logic        reset,
	input logic        wb_cyc,
	input logic        wb_stb,
	input logic        wb_ack,
	input logic        count_enable,
	input logic        count_clear,
	input logic        latch,
	input ctrl_state_t state
);
	timeunit 1ns;
	timeprecision 1ps;

	// ack answers a request seen on the edge before.
	ack_follows_request: assert property (@(posedge integration_clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack raised without wb_cyc and wb_stb on the previous edge");

	ack_single_cycle: assert property (@(posedge integration_clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles");

	// counting starts only from idle, on the edge that clears the counters.
	enable_after_clear: assert property (@(posedge integration_clk) disable iff (reset)
		$rose(count_enable) |-> $past((state == ST_IDLE) && count_clear))
		else $error("count_enable rose without a start that cleared the counters");

	latch_single_cycle: assert property (@(posedge integration_clk) disable iff (reset)
		latch |=> !latch)
		else $error("latch stayed high for two cycles");

endmodule

bind xc_control xc_assertions checks (
	.integration_clk (integration_clk),
	.reset           (reset),
	.wb_cyc          (wb_cyc),
	.wb_stb          (wb_stb),
	.wb_ack          (wb_ack),
	.count_enable    (count_enable),
	.count_clear     (count_clear),
	.latch           (latch),
	.state           (state)
);

// File: bench/xc_tb.sv
// directed testbench for xc_top; stops at the first failed check, line_in driven synchronously.
module xc_tb import xc_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic                  integration_clk;
	logic                  reset;
	logic [NUM_INPUTS-1:0] line_in;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [ADDR_WIDTH-1:0] wb_adr;
	logic [DATA_WIDTH-1:0] wb_dat_w;
	logic [DATA_WIDTH-1:0] wb_dat_r;
	logic                  wb_ack;
	logic                  integrating;
	logic [NUM_INPUTS-1:0] toggle_mask;
	logic [NUM_INPUTS-1:0] model_level;
	logic [NUM_INPUTS-1:0] model_toggle;
	int                    seed = 32'hcfb;
	int                    cycle_count = 0;
	int                    integrate_cycles = 0;

	xc_top DUT (.*);

	always #50 integration_clk = ~integration_clk;

	// masked lines flip on every edge.
	always @(posedge integration_clk) begin
		if (toggle_mask != '0)
			line_in <= line_in ^ toggle_mask;
	end

	// edges on which the counters were enabled.
	always @(posedge integration_clk) begin
		if (integrating)
			integrate_cycles <= integrate_cycles + 1;
	end

	// tests take about 1500 cycles, so 6000 leaves a wide margin.
	always @(posedge integration_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == 6000)
			abort_run("timeout: the run went past 6000 clock cycles");
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic bus_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] data, output logic [DATA_WIDTH-1:0] rdata);
		int waited;
		waited = 0;
		@(posedge integration_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= addr;
		wb_dat_w <= data;
		@(negedge integration_clk);
		while (!wb_ack) begin
			waited++;
			if (waited > 20)
				abort_run("bus timeout: no wb_ack within 20 cycles");
			@(negedge integration_clk);
		end
		rdata = wb_dat_r;
		@(posedge integration_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		logic [DATA_WIDTH-1:0] unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic wb_read(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
		bus_access(1'b0, addr, '0, data);
	endtask

	task automatic check_word(input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] expected, input string name);
		logic [DATA_WIDTH-1:0] actual;
		wb_read(addr, actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
	endtask

	task automatic check_count(input int index, input logic [COUNT_WIDTH-1:0] expected);
		check_word(ADDR_WIDTH'(RESULT_BASE + index), DATA_WIDTH'(expected),
			$sformatf("result[%0d]", index));
	endtask

	task automatic check_status(input logic busy, input logic done, input logic overflow);
		check_word(REG_STATUS, {{(DATA_WIDTH-3){1'b0}}, overflow, done, busy}, "status");
	endtask

	// integrating must have been high for exactly the programmed length.
	task automatic check_integrate_cycles(input int since, input int expected);
		int actual;
		actual = integrate_cycles - since;
		if (actual != expected)
			abort_run($sformatf("MISMATCH at %0t: integrating cycles expected %0d, got %0d",
				$time, expected, actual));
	endtask

	// line value at sample n of the pattern; a toggling line alternates with n.
	function automatic logic sample(input int line, input int n);
		if (model_toggle[line])
			return model_level[line] ^ n[0];
		return model_level[line];
	endfunction

	// expected count from the correlation rules, edge 0 being the first enabled edge.
	function automatic logic [COUNT_WIDTH-1:0] expected_count(input int index, input int length);
		int   count;
		int   a;
		int   c;
		int   lag;
		int   pair;
		logic hit;
		count = 0;
		pair  = 0;
		a     = index / MAX_LAG;
		c     = a;
		lag   = index % MAX_LAG;
		if (index >= AUTO_COUNT) begin
			lag = (index - AUTO_COUNT) % CROSS_LAGS - (MAX_LAG - 1);
			for (int i = 0; i < NUM_INPUTS; i++) begin
				for (int j = i + 1; j < NUM_INPUTS; j++) begin
					if (pair == (index - AUTO_COUNT) / CROSS_LAGS) begin
						a = i;
						c = j;
					end
					pair++;
				end
			end
		end
		for (int e = 0; e < length; e++) begin
			if (index < AUTO_COUNT)
				hit = sample(a, e) && sample(a, e - lag);
			else if (lag >= 0)
				hit = sample(a, e - lag) && sample(c, e);
			else
				hit = sample(a, e) && sample(c, e + lag);
			if (hit && (count < int'(COUNT_MAX)))
				count++;
		end
		return COUNT_WIDTH'(count);
	endfunction

	task automatic set_lines(input logic [NUM_INPUTS-1:0] level, input logic [NUM_INPUTS-1:0] toggle);
		@(posedge integration_clk);
		toggle_mask <= '0;
		@(posedge integration_clk);
		line_in <= level;
		@(posedge integration_clk);
		toggle_mask <= toggle;
		model_level  = level;
		model_toggle = toggle;
		// history fills before the next start.
		repeat (MAX_LAG + 1) @(posedge integration_clk);
	endtask

	task automatic wait_done();
		logic [DATA_WIDTH-1:0] word;
		int                    polls;
		word  = '0;
		polls = 0;
		while (!word[1]) begin
			if (polls == 200)
				abort_run("done was never set after START");
			wb_read(REG_STATUS, word);
			polls++;
		end
	endtask

	task automatic run_integration(input int length);
		int since;
		wb_write(REG_LENGTH, DATA_WIDTH'(length));
		since = integrate_cycles;
		wb_write(REG_CTRL, DATA_WIDTH'(CMD_START));
		wait_done();
		check_integrate_cycles(since, length);
	endtask

	task automatic check_all(input int length);
		for (int n = 0; n < RESULT_COUNT; n++)
			check_count(n, expected_count(n, length));
	endtask

	task automatic test_reset_state();
		logic [DATA_WIDTH-1:0] rand_word;
		logic [DATA_WIDTH-1:0] length_word;
		check_status(1'b0, 1'b0, 1'b0);
		check_count(9, '0);
		check_word(ADDR_WIDTH'(100), '0, "unmapped");
		rand_word   = $random(seed);
		length_word = DATA_WIDTH'(rand_word[LENGTH_WIDTH-1:0]);
		wb_write(REG_LENGTH, length_word);
		check_word(REG_LENGTH, length_word, "length");
		wb_write(REG_STATUS, '1);
		check_word(REG_LENGTH, length_word, "length");
		check_status(1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_toggle_lines();
		logic [DATA_WIDTH-1:0] rand_word;
		int                    length;
		rand_word = $random(seed);
		length    = 20 + 2 * (int'(rand_word[15:0]) % 21);
		// line 1 starts inverted from line 0 and flips with it.
		set_lines(4'b0110, 4'b0011);
		run_integration(length);
		check_all(length);
		check_status(1'b0, 1'b1, 1'b0);
	endtask

	task automatic test_start_while_busy();
		int since;
		// lines 0 and 2 saturate, so the clear has an overflow to drop.
		set_lines(4'b0101, 4'b0000);
		wb_write(REG_LENGTH, DATA_WIDTH'(300));
		since = integrate_cycles;
		wb_write(REG_CTRL, DATA_WIDTH'(CMD_START));
		wb_write(REG_LENGTH, DATA_WIDTH'(8));
		wb_write(REG_CTRL, DATA_WIDTH'(CMD_START));
		check_status(1'b1, 1'b0, 1'b0);
		wait_done();
		check_integrate_cycles(since, 300);
		check_all(300);
		check_status(1'b0, 1'b1, 1'b1);
		wb_write(REG_CTRL, DATA_WIDTH'(CMD_CLEAR));
		check_status(1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		integration_clk = 1'b0;
		reset           = 1'b1;
		line_in         = '0;
		toggle_mask     = '0;
		model_level     = '0;
		model_toggle    = '0;
		wb_cyc          = 1'b0;
		wb_stb          = 1'b0;
		wb_we           = 1'b0;
		wb_adr          = '0;
		wb_dat_w        = '0;
		repeat (16) @(posedge integration_clk);
		reset <= 1'b0;

		test_reset_state();
		// line 0 alone.
		set_lines(4'b0001, 4'b0000);
		run_integration(20);
		check_all(20);
		check_status(1'b0, 1'b1, 1'b0);
		test_toggle_lines();
		// every counter saturates.
		set_lines(4'b1111, 4'b0000);
		run_integration(300);
		check_all(300);
		check_status(1'b0, 1'b1, 1'b1);
		test_start_while_busy();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the correlator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module xc_tb -Mdir obj_dir -f all.f || { echo "build failed"; exit 1; }
sim_output=$(./obj_dir/Vxc_tb 2>&1)
echo "$sim_output"
echo "$sim_output" | grep -qF "*** TEST PASSED ***" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: verilog/xc_autocorr.sv
// autocorrelation counters at lags 0 to MAX_LAG-1; they stick at COUNT_MAX until cleared.
module xc_autocorr import xc_pkg::*; (
	input  logic                              integration_clk,
	input  logic                              reset,
	input  logic [NUM_INPUTS*MAX_LAG-1:0]     taps,
	input  logic                              count_enable,
	input  logic                              count_clear,
	output logic [AUTO_COUNT*COUNT_WIDTH-1:0] auto_counts,
	output logic [AUTO_COUNT-1:0]             auto_saturated
);

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		for (genvar l = 0; l < MAX_LAG; l++) begin : g_lag
			localparam int IDX = i * MAX_LAG + l;

			logic [COUNT_WIDTH-1:0] count;
			logic                   hit;

			// lag 0 reduces to the plain pulse count.
			assign hit = taps[i*MAX_LAG] && taps[IDX];

			always_ff @(posedge integration_clk) begin
				if (reset || count_clear)
					count <= '0;
				else if (count_enable)
					count <= count_next(count, hit);
			end

			assign auto_counts[IDX*COUNT_WIDTH +: COUNT_WIDTH] = count;
			assign auto_saturated[IDX] = (count == COUNT_MAX);
		end
	end

endmodule

// File: verilog/xc_control.sv
// wishbone classic slave with one-cycle ack; drop wb_stb between accesses. START while busy is ignored.
module xc_control import xc_pkg::*; (
	input  logic                   integration_clk,
	input  logic                   reset,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [ADDR_WIDTH-1:0]  wb_adr,
	input  logic [DATA_WIDTH-1:0]  wb_dat_w,
	output logic [DATA_WIDTH-1:0]  wb_dat_r,
	output logic                   wb_ack,
	output logic                   count_enable,
	output logic                   count_clear,
	output logic                   latch,
	output logic [INDEX_WIDTH-1:0] result_index,
	input  logic [COUNT_WIDTH-1:0] result_data,
	input  logic                   overflow,
	output logic                   integrating
);

	ctrl_state_t             state;
	cmd_t                    cmd;
	logic [LENGTH_WIDTH-1:0] length;
	logic [LENGTH_WIDTH-1:0] remaining;
	logic                    done;
	logic                    latch_q;
	logic                    busy;
	logic                    access;
	logic                    write;
	logic                    ctrl_write;
	logic                    start_req;
	logic                    clear_req;
	logic                    in_result;
	logic [ADDR_WIDTH-1:0]   result_offset;
	logic [DATA_WIDTH-1:0]   read_word;

	// an access is taken on the edge that raises ack.
	assign access     = wb_cyc && wb_stb && !wb_ack;
	assign write      = access && wb_we;
	assign ctrl_write = write && (wb_adr == REG_CTRL);
	assign cmd        = cmd_t'(wb_dat_w[1:0]);

	assign start_req = ctrl_write && (cmd == CMD_START) && (state == ST_IDLE);
	assign clear_req = ctrl_write && (cmd == CMD_CLEAR);

	// result window decode.
	assign in_result     = (wb_adr >= ADDR_WIDTH'(RESULT_BASE)) &&
	                       (wb_adr < ADDR_WIDTH'(RESULT_BASE + RESULT_COUNT));
	assign result_offset = wb_adr - ADDR_WIDTH'(RESULT_BASE);
	assign result_index  = result_offset[INDEX_WIDTH-1:0];

	assign busy         = (state != ST_IDLE);
	assign count_enable = (state == ST_INTEGRATE);
	assign integrating  = count_enable;
	assign count_clear  = start_req || clear_req;
	// a clear in the latch cycle drops the snapshot.
	assign latch        = (state == ST_LATCH) && !clear_req;

	always_comb begin
		case (reg_addr_t'(wb_adr))
			REG_STATUS: read_word = {{(DATA_WIDTH-3){1'b0}}, overflow, done, busy};
			REG_LENGTH: read_word = {{(DATA_WIDTH-LENGTH_WIDTH){1'b0}}, length};
			default: begin
				if (in_result)
					read_word = {{(DATA_WIDTH-COUNT_WIDTH){1'b0}}, result_data};
				else
					read_word = '0;
			end
		endcase
	end

	always_ff @(posedge integration_clk) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
		end else begin
			wb_ack <= access;
			if (access && !wb_we)
				wb_dat_r <= read_word;
		end
	end

	always_ff @(posedge integration_clk) begin
		if (reset)
			length <= '0;
		else if (write && (wb_adr == REG_LENGTH))
			length <= wb_dat_w[LENGTH_WIDTH-1:0];
	end

	// integration sequence.
	always_ff @(posedge integration_clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			remaining <= '0;
		end else if (clear_req) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_req) begin
						remaining <= length;
						state     <= (length == '0) ? ST_LATCH : ST_INTEGRATE;
					end
				end
				ST_INTEGRATE: begin
					remaining <= remaining - 1'b1;
					if (remaining == LENGTH_WIDTH'(1))
						state <= ST_LATCH;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// done follows the snapshot by one edge.
	always_ff @(posedge integration_clk) begin
		if (reset) begin
			latch_q <= 1'b0;
			done    <= 1'b0;
		end else begin
			latch_q <= latch;
			if (start_req || clear_req)
				done <= 1'b0;
			else if (latch_q)
				done <= 1'b1;
		end
	end

endmodule

// File: verilog/xc_crosscorr.sv
// cross counters for each line pair (a,c) with a below c, lags -(MAX_LAG-1) to MAX_LAG-1.
module xc_crosscorr import xc_pkg::*; (
	input  logic                               integration_clk,
	input  logic                               reset,
	input  logic [NUM_INPUTS*MAX_LAG-1:0]      taps,
	input  logic                               count_enable,
	input  logic                               count_clear,
	output logic [CROSS_COUNT*COUNT_WIDTH-1:0] cross_counts,
	output logic [CROSS_COUNT-1:0]             cross_saturated
);

	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_first
		for (genvar c = a + 1; c < NUM_INPUTS; c++) begin : g_second
			// baselines run (0,1), (0,2), (0,3), (1,2) and so on.
			localparam int BASE = a * NUM_INPUTS - a * (a + 1) / 2 + (c - a - 1);

			for (genvar m = 0; m < CROSS_LAGS; m++) begin : g_lag
				localparam int LAG   = m - (MAX_LAG - 1);
				localparam int IDX   = BASE * CROSS_LAGS + m;
				// positive lag delays line a, negative lag delays line c.
				localparam int TAP_A = a * MAX_LAG + ((LAG > 0) ? LAG : 0);
				localparam int TAP_C = c * MAX_LAG + ((LAG < 0) ? -LAG : 0);

				logic [COUNT_WIDTH-1:0] count;
				logic                   hit;

				assign hit = taps[TAP_A] && taps[TAP_C];

				always_ff @(posedge integration_clk) begin
					if (reset || count_clear)
						count <= '0;
					else if (count_enable)
						count <= count_next(count, hit);
				end

				assign cross_counts[IDX*COUNT_WIDTH +: COUNT_WIDTH] = count;
				assign cross_saturated[IDX] = (count == COUNT_MAX);
			end
		end
	end

endmodule

// File: verilog/xc_delay_line.sv
// sample history per line; tap j holds the line as it was j+1 edges earlier, no input synchronizer.
module xc_delay_line import xc_pkg::*; (
	input  logic                          integration_clk,
	input  logic                          reset,
	input  logic [NUM_INPUTS-1:0]         line_in,
	output logic [NUM_INPUTS*MAX_LAG-1:0] taps
);

	logic [NUM_INPUTS*MAX_LAG-1:0] history;

	// new sample enters bit 0, older ones move up.
	always_ff @(posedge integration_clk) begin
		if (reset) begin
			history <= '0;
		end else begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				history[i*MAX_LAG +: MAX_LAG] <=
					{history[i*MAX_LAG +: MAX_LAG-1], line_in[i]};
			end
		end
	end

	assign taps = history;

endmodule

// File: verilog/xc_pkg.sv
// shared sizes, register map and opcodes; the result layout assumes NUM_INPUTS is 4 and MAX_LAG is 4.
package xc_pkg;

	// datapath sizes.
	localparam int NUM_INPUTS    = 4;
	localparam int MAX_LAG       = 4;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int CROSS_LAGS    = 2 * MAX_LAG - 1;
	localparam int COUNT_WIDTH   = 8;
	localparam int AUTO_COUNT    = NUM_INPUTS * MAX_LAG;
	localparam int CROSS_COUNT   = NUM_BASELINES * CROSS_LAGS;
	localparam int RESULT_COUNT  = AUTO_COUNT + CROSS_COUNT;
	localparam int INDEX_WIDTH   = $clog2(RESULT_COUNT);

	localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

	// host bus.
	localparam int ADDR_WIDTH   = 7;
	localparam int DATA_WIDTH   = 32;
	localparam int LENGTH_WIDTH = 16;
	localparam int RESULT_BASE  = 16;

	// register word addresses, results start at RESULT_BASE.
	typedef enum logic [ADDR_WIDTH-1:0] {
		REG_CTRL   = 7'd0,
		REG_STATUS = 7'd1,
		REG_LENGTH = 7'd2
	} reg_addr_t;

	// opcodes written to REG_CTRL.
	typedef enum logic [1:0] {
		CMD_NOP   = 2'd0,
		CMD_START = 2'd1,
		CMD_CLEAR = 2'd2
	} cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE      = 2'd0,
		ST_INTEGRATE = 2'd1,
		ST_LATCH     = 2'd2
	} ctrl_state_t;

	// one step of a saturating counter.
	function automatic logic [COUNT_WIDTH-1:0] count_next(
		input logic [COUNT_WIDTH-1:0] count,
		input logic                   hit
	);
		if (hit && (count != COUNT_MAX))
			return count + 1'b1;
		return count;
	endfunction

endpackage

// File: verilog/xc_result_bank.sv
// holds the last snapshot until the next latch; result_index must stay below RESULT_COUNT.
module xc_result_bank import xc_pkg::*; (
	input  logic                               integration_clk,
	input  logic                               reset,
	input  logic                               latch,
	input  logic                               count_clear,
	input  logic [AUTO_COUNT*COUNT_WIDTH-1:0]  auto_counts,
	input  logic [CROSS_COUNT*COUNT_WIDTH-1:0] cross_counts,
	input  logic [AUTO_COUNT-1:0]              auto_saturated,
	input  logic [CROSS_COUNT-1:0]             cross_saturated,
	input  logic [INDEX_WIDTH-1:0]             result_index,
	output logic [COUNT_WIDTH-1:0]             result_data,
	output logic                               overflow
);

	logic [COUNT_WIDTH-1:0] held [RESULT_COUNT];
	logic                   any_saturated;

	assign any_saturated = (|auto_saturated) || (|cross_saturated);

	// autocorrelation first, then cross results.
	always_ff @(posedge integration_clk) begin
		if (reset) begin
			for (int n = 0; n < RESULT_COUNT; n++)
				held[n] <= '0;
		end else if (latch) begin
			for (int n = 0; n < AUTO_COUNT; n++)
				held[n] <= auto_counts[n*COUNT_WIDTH +: COUNT_WIDTH];
			for (int n = 0; n < CROSS_COUNT; n++)
				held[AUTO_COUNT+n] <= cross_counts[n*COUNT_WIDTH +: COUNT_WIDTH];
		end
	end

	// overflow follows the counters, so a clear drops it too.
	always_ff @(posedge integration_clk) begin
		if (reset || count_clear)
			overflow <= 1'b0;
		else if (latch)
			overflow <= any_saturated;
	end

	// combinational read, registered in the bus slave.
	assign result_data = held[result_index];

endmodule

// File: verilog/xc_top.sv
// correlator top; line_in is sampled directly on integration_clk and must already be synchronous.
module xc_top import xc_pkg::*; (
	input  logic                  integration_clk,
	input  logic                  reset,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [ADDR_WIDTH-1:0] wb_adr,
	input  logic [DATA_WIDTH-1:0] wb_dat_w,
	output logic [DATA_WIDTH-1:0] wb_dat_r,
	output logic                  wb_ack,
	output logic                  integrating
);

	logic                               count_enable;
	logic                               count_clear;
	logic                               latch;
	logic [INDEX_WIDTH-1:0]             result_index;
	logic [COUNT_WIDTH-1:0]             result_data;
	logic                               overflow;
	logic [NUM_INPUTS*MAX_LAG-1:0]      taps;
	logic [AUTO_COUNT*COUNT_WIDTH-1:0]  auto_counts;
	logic [AUTO_COUNT-1:0]              auto_saturated;
	logic [CROSS_COUNT*COUNT_WIDTH-1:0] cross_counts;
	logic [CROSS_COUNT-1:0]             cross_saturated;

	xc_control control (
		.integration_clk (integration_clk),
		.reset           (reset),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.count_enable    (count_enable),
		.count_clear     (count_clear),
		.latch           (latch),
		.result_index    (result_index),
		.result_data     (result_data),
		.overflow        (overflow),
		.integrating     (integrating)
	);

	xc_delay_line delay_line (
		.integration_clk (integration_clk),
		.reset           (reset),
		.line_in         (line_in),
		.taps            (taps)
	);

	xc_autocorr autocorr (
		.integration_clk (integration_clk),
		.reset           (reset),
		.taps            (taps),
		.count_enable    (count_enable),
		.count_clear     (count_clear),
		.auto_counts     (auto_counts),
		.auto_saturated  (auto_saturated)
	);

	xc_crosscorr crosscorr (
		.integration_clk (integration_clk),
		.reset           (reset),
		.taps            (taps),
		.count_enable    (count_enable),
		.count_clear     (count_clear),
		.cross_counts    (cross_counts),
		.cross_saturated (cross_saturated)
	);

	xc_result_bank result_bank (
		.integration_clk (integration_clk),
		.reset           (reset),
		.latch           (latch),
		.count_clear     (count_clear),
		.auto_counts     (auto_counts),
		.cross_counts    (cross_counts),
		.auto_saturated  (auto_saturated),
		.cross_saturated (cross_saturated),
		.result_index    (result_index),
		.result_data     (result_data),
		.overflow        (overflow)
	);

endmodule
